// File: trigger_pkg.sv
// trigger path package: widths, value typedefs, record structs, FSM state enums
package trigger_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int n_chan          = 5;  // digitizer channels
    localparam int trig_num_w      = 24; // trigger and event numbers
    localparam int timestamp_w     = 44; // counted in ttc_clk cycles
    localparam int trig_type_w     = 3;
    localparam int delay_w         = 32;
    localparam int fifo_depth_log2 = 4;  // 16 records per queue

    // ----------------------------------------
    // value types
    // ----------------------------------------
    typedef logic [trig_num_w-1:0]  trig_num_t;
    typedef logic [timestamp_w-1:0] timestamp_t;
    typedef logic [trig_type_w-1:0] trig_type_t;  // muon fill, laser, pedestal ...
    typedef logic [n_chan-1:0]      chan_mask_t;  // one bit per channel
    typedef logic [delay_w-1:0]     delay_t;      // trigger delay in cycles

    // ----------------------------------------
    // records
    // ----------------------------------------

    // entry of the trigger FIFO, written by the receiver
    typedef struct packed {
        trig_num_t  trig_num;
        trig_type_t trig_type;
        timestamp_t timestamp;
    } trig_rec_t;

    // entry of the event FIFO, written by the acquisition controller
    typedef struct packed {
        trig_num_t  trig_num;
        trig_num_t  event_num;
        trig_type_t trig_type;
        chan_mask_t chan_mask;   // zero means empty event
    } acq_rec_t;

    // rides along with the acquisition strobe
    typedef struct packed {
        trig_num_t  trig_num;
        trig_type_t trig_type;
    } acq_req_t;

    // bundle handed to the command manager
    typedef struct packed {
        trig_num_t  event_num;
        trig_num_t  trig_num;
        trig_type_t trig_type;
        timestamp_t timestamp;
    } readout_info_t;

    // ----------------------------------------
    // FSM states
    // ----------------------------------------
    typedef enum logic [2:0] {
        cac_idle,
        cac_delay,      // counting down trig_delay
        cac_fire,       // chan_trig pulse
        cac_wait_done,
        cac_log         // event FIFO write
    } cac_state_t;

    typedef enum logic [1:0] {
        tp_idle,
        tp_issue,       // request strobe
        tp_wait_done
    } tp_state_t;

endpackage

// File: ttc_trigger_receiver.sv
// TTC trigger receiver: acceptance, trigger numbering, timestamp counter, rate error flag
module ttc_trigger_receiver import trigger_pkg::*; (
    input  logic       ttc_clk,
    input  logic       rst,
    input  logic       rst_trigger_num,        // TTC channel B
    input  logic       rst_trigger_timestamp,  // TTC channel B
    input  logic       ttc_trigger,
    input  trig_type_t trig_type,
    input  logic       acq_ready,              // controller idle and FIFOs have room
    output logic       acq_strobe,
    output acq_req_t   acq_req,
    output logic       fifo_write,             // trigger FIFO
    output trig_rec_t  fifo_rec,
    output trig_num_t  trig_num,               // last accepted trigger
    output timestamp_t trig_timestamp,         // its timestamp
    output logic       error_trig_rate         // sticky
);

    timestamp_t ts_cnt;     // free running
    trig_num_t  num_base;   // counter after a possible channel B reset
    trig_num_t  num_next;
    logic       accept;

    assign accept   = ttc_trigger && acq_ready;
    assign num_base = rst_trigger_num ? '0 : trig_num;
    assign num_next = num_base + trig_num_t'(1);   // numbering starts at 1

    // ----------------------------------------
    // timestamp counter
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst || rst_trigger_timestamp) begin
            ts_cnt <= '0;
        end else begin
            ts_cnt <= ts_cnt + timestamp_t'(1);
        end
    end

    // ----------------------------------------
    // acceptance and numbering
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            acq_strobe      <= 1'b0;
            trig_num        <= '0;
            trig_timestamp  <= '0;
            error_trig_rate <= 1'b0;
        end else begin
            acq_strobe <= accept;                    // single cycle
            trig_num   <= accept ? num_next : num_base;
            if (accept) begin
                trig_timestamp <= ts_cnt;
            end
            // dropped trigger while the path is busy
            if (ttc_trigger && !acq_ready) begin
                error_trig_rate <= 1'b1;
            end
        end
    end

    // record register loaded with each accepted trigger
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            fifo_rec.trig_num  <= num_next;
            fifo_rec.trig_type <= trig_type;
            fifo_rec.timestamp <= ts_cnt;
        end
    end

    // FIFO entry and request share one register, so the numbers always agree
    assign fifo_write        = acq_strobe;
    assign acq_req.trig_num  = fifo_rec.trig_num;
    assign acq_req.trig_type = fifo_rec.trig_type;

endmodule

// File: channel_acq_controller.sv
// channel acquisition controller: trigger delay, channel fan-out, done collection, event numbering
module channel_acq_controller import trigger_pkg::*; (
    input  logic       ttc_clk,
    input  logic       rst,
    input  logic       rst_trigger_num,
    input  chan_mask_t chan_en,      // channels taking part
    input  delay_t     trig_delay,   // cycles between request and chan_trig
    input  logic       acq_strobe,
    input  acq_req_t   acq_req,
    input  logic       fifo_space,   // both FIFOs not full
    output logic       acq_ready,
    output chan_mask_t chan_trig,
    input  chan_mask_t chan_dones,   // level, held until next chan_trig
    output logic       fifo_write,   // event FIFO
    output acq_rec_t   fifo_rec,
    output cac_state_t state
);

    chan_mask_t mask_q;      // chan_en at request time
    acq_req_t   req_q;
    delay_t     delay_cnt;
    trig_num_t  event_num;   // last logged event
    trig_num_t  event_base;
    logic       all_done;
    logic       to_log;      // entering cac_log next edge

    // the strobe cycle itself is busy too, keeps a back-to-back trigger out
    assign acq_ready = (state == cac_idle) && fifo_space && !acq_strobe;

    assign all_done   = (chan_dones & mask_q) == mask_q;
    assign event_base = rst_trigger_num ? '0 : event_num;
    assign to_log     = ((state == cac_idle) && acq_strobe && (chan_en == '0)) ||
                        ((state == cac_wait_done) && all_done);

    assign chan_trig  = (state == cac_fire) ? mask_q : '0;   // one-cycle pulse
    assign fifo_write = (state == cac_log);

    assign fifo_rec.trig_num  = req_q.trig_num;
    assign fifo_rec.event_num = event_num;   // already bumped on entry to log
    assign fifo_rec.trig_type = req_q.trig_type;
    assign fifo_rec.chan_mask = mask_q;

    // ----------------------------------------
    // control FSM
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state     <= cac_idle;
            event_num <= '0;
        end else begin
            event_num <= to_log ? event_base + trig_num_t'(1) : event_base;
            case (state)
                cac_idle: begin
                    if (acq_strobe) begin
                        if (chan_en == '0) begin
                            state <= cac_log;      // nothing to fire
                        end else if (trig_delay == '0) begin
                            state <= cac_fire;
                        end else begin
                            state <= cac_delay;
                        end
                    end
                end
                cac_delay: begin
                    if (delay_cnt == '0) begin
                        state <= cac_fire;
                    end
                end
                cac_fire:      state <= cac_wait_done;
                cac_wait_done: begin
                    if (all_done) begin
                        state <= cac_log;
                    end
                end
                cac_log:       state <= cac_idle;
                default:       state <= cac_idle;
            endcase
        end
    end

    // ----------------------------------------
    // request latch and delay counter
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if ((state == cac_idle) && acq_strobe) begin
            mask_q    <= chan_en;
            req_q     <= acq_req;
            delay_cnt <= trig_delay - delay_t'(1);   // last delay cycle at zero
        end else if (state == cac_delay) begin
            delay_cnt <= delay_cnt - delay_t'(1);
        end
    end

endmodule

// File: record_fifo.sv
// single-clock first-word-fall-through record FIFO
module record_fifo import trigger_pkg::*; #(
    parameter int  depth_log2 = fifo_depth_log2,
    parameter type rec_t      = trig_rec_t
) (
    input  logic ttc_clk,
    input  logic rst,
    input  logic write,
    input  rec_t din,
    input  logic pop,
    output rec_t dout,        // head record, valid with not_empty
    output logic not_empty,
    output logic not_full
);

    rec_t                  mem [1 << depth_log2];
    logic [depth_log2-1:0] wr_ptr;   // wraps on its own
    logic [depth_log2-1:0] rd_ptr;
    logic [depth_log2:0]   count;    // msb set means full
    logic                  do_write;
    logic                  do_pop;

    // write on full and pop on empty are dropped
    assign do_write  = write && not_full;
    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);
    assign not_full  = !count[depth_log2];
    assign dout      = mem[rd_ptr];   // fall-through head

    always_ff @(posedge ttc_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)   rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // none, or both at once
            endcase
        end
    end

endmodule

// File: trigger_processor.sv
// trigger processor: pairs FIFO heads, checks number and type, issues readout requests
module trigger_processor import trigger_pkg::*; (
    input  logic          ttc_clk,
    input  logic          rst,
    input  logic          trig_valid,        // trigger FIFO not empty
    input  trig_rec_t     trig_head,
    input  logic          acq_valid,         // event FIFO not empty
    input  acq_rec_t      acq_head,
    output logic          pop,               // both FIFOs at once
    input  logic          readout_ready,     // command manager idle
    input  logic          readout_done,      // strobe
    output logic          initiate_readout,
    output logic          send_empty_event,
    output readout_info_t info,
    output logic          error_trig_num,    // sticky
    output logic          error_trig_type    // sticky
);

    tp_state_t state;
    logic      take;      // pairing the two heads this cycle
    logic      empty_q;   // no channel was enabled

    assign take = (state == tp_idle) && trig_valid && acq_valid && readout_ready;
    assign pop  = take;

    // request strobes, one cycle in tp_issue
    assign initiate_readout = (state == tp_issue) && !empty_q;
    assign send_empty_event = (state == tp_issue) && empty_q;

    // ----------------------------------------
    // request FSM
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state           <= tp_idle;
            empty_q         <= 1'b0;
            info            <= '0;
            error_trig_num  <= 1'b0;
            error_trig_type <= 1'b0;
        end else begin
            case (state)
                tp_idle: begin
                    if (take) begin
                        // info holds until the next pairing
                        info.event_num <= acq_head.event_num;
                        info.trig_num  <= trig_head.trig_num;
                        info.trig_type <= trig_head.trig_type;
                        info.timestamp <= trig_head.timestamp;
                        empty_q        <= (acq_head.chan_mask == '0);
                        // the two queues must stay in step
                        if (trig_head.trig_num != acq_head.trig_num) begin
                            error_trig_num <= 1'b1;
                        end
                        if (trig_head.trig_type != acq_head.trig_type) begin
                            error_trig_type <= 1'b1;
                        end
                        state <= tp_issue;
                    end
                end
                tp_issue: begin
                    // an immediate answer is not lost
                    state <= readout_done ? tp_idle : tp_wait_done;
                end
                tp_wait_done: begin
                    if (readout_done) begin
                        state <= tp_idle;
                    end
                end
                default: state <= tp_idle;
            endcase
        end
    end

endmodule

// File: trigger_top.sv
// trigger path top level: receiver, acquisition controller, two record FIFOs, processor
module trigger_top import trigger_pkg::*; (
    input  logic          ttc_clk,
    input  logic          rst,
    input  logic          rst_trigger_num,        // TTC channel B
    input  logic          rst_trigger_timestamp,  // TTC channel B
    input  logic          ttc_trigger,
    input  trig_type_t    trig_type,
    input  chan_mask_t    chan_en,
    input  delay_t        trig_delay,
    input  chan_mask_t    chan_dones,
    output chan_mask_t    chan_trig,
    input  logic          readout_ready,
    input  logic          readout_done,
    output logic          initiate_readout,
    output logic          send_empty_event,
    output readout_info_t readout_info,
    output trig_num_t     trig_num,
    output timestamp_t    trig_timestamp,
    output logic          error_trig_rate,
    output logic          error_trig_num,
    output logic          error_trig_type
);

    // ----------------------------------------
    // wires
    // ----------------------------------------
    logic       acq_strobe, acq_ready;
    acq_req_t   acq_req;
    logic       trig_write, trig_valid, trig_not_full;
    trig_rec_t  trig_wr_rec, trig_head;
    logic       acq_write, acq_valid, acq_not_full;
    acq_rec_t   acq_wr_rec, acq_head;
    logic       pop;           // shared by both FIFOs
    wire        fifo_space = trig_not_full & acq_not_full;

    // ----------------------------------------
    // instances
    // ----------------------------------------
    ttc_trigger_receiver receiver0 (
        .ttc_clk, .rst, .rst_trigger_num, .rst_trigger_timestamp,
        .ttc_trigger, .trig_type, .acq_ready, .acq_strobe, .acq_req,
        .fifo_write(trig_write), .fifo_rec(trig_wr_rec),
        .trig_num, .trig_timestamp, .error_trig_rate
    );

    channel_acq_controller cac0 (
        .ttc_clk, .rst, .rst_trigger_num, .chan_en, .trig_delay,
        .acq_strobe, .acq_req, .fifo_space, .acq_ready, .chan_trig, .chan_dones,
        .fifo_write(acq_write), .fifo_rec(acq_wr_rec), .state()
    );

    record_fifo #(.depth_log2(fifo_depth_log2), .rec_t(trig_rec_t)) trig_fifo (
        .ttc_clk, .rst, .write(trig_write), .din(trig_wr_rec), .pop,
        .dout(trig_head), .not_empty(trig_valid), .not_full(trig_not_full)
    );

    record_fifo #(.depth_log2(fifo_depth_log2), .rec_t(acq_rec_t)) acq_fifo (
        .ttc_clk, .rst, .write(acq_write), .din(acq_wr_rec), .pop,
        .dout(acq_head), .not_empty(acq_valid), .not_full(acq_not_full)
    );

    trigger_processor processor0 (
        .ttc_clk, .rst, .trig_valid, .trig_head, .acq_valid, .acq_head, .pop,
        .readout_ready, .readout_done, .initiate_readout, .send_empty_event,
        .info(readout_info), .error_trig_num, .error_trig_type
    );

endmodule

// File: trigger_top_asserts.sv
// concurrent checks on trigger path strobes, channel mask, request exclusivity and FIFO writes
module trigger_top_asserts import trigger_pkg::*; (
    input logic       ttc_clk,
    input logic       rst,
    input logic       acq_strobe,
    input chan_mask_t chan_trig,
    input chan_mask_t chan_en,
    input logic       initiate_readout,
    input logic       send_empty_event,
    input logic       trig_write,
    input logic       trig_not_full,
    input logic       acq_write,
    input logic       acq_not_full
);

    // ----------------------------------------
    // single-cycle strobes
    // ----------------------------------------
    a_acq_strobe_pulse: assert property (@(posedge ttc_clk) disable iff (rst)
        acq_strobe |=> !acq_strobe) else $error("acq_strobe held past one cycle");
    a_chan_trig_pulse: assert property (@(posedge ttc_clk) disable iff (rst)
        (chan_trig != '0) |=> (chan_trig == '0)) else $error("chan_trig held past one cycle");
    a_request_pulse: assert property (@(posedge ttc_clk) disable iff (rst)
        (initiate_readout || send_empty_event) |=> !(initiate_readout || send_empty_event))
        else $error("readout request held past one cycle");

    // mask and exclusivity
    a_chan_subset: assert property (@(posedge ttc_clk) disable iff (rst)
        (chan_trig & ~chan_en) == '0) else $error("chan_trig on a disabled channel");
    a_request_excl: assert property (@(posedge ttc_clk) disable iff (rst)
        !(initiate_readout && send_empty_event)) else $error("both request strobes high");

    // no write into a full queue
    a_trig_fifo_full: assert property (@(posedge ttc_clk) disable iff (rst)
        !(trig_write && !trig_not_full)) else $error("trigger FIFO written while full");
    a_acq_fifo_full: assert property (@(posedge ttc_clk) disable iff (rst)
        !(acq_write && !acq_not_full)) else $error("event FIFO written while full");

endmodule

bind trigger_top trigger_top_asserts asserts0 (
    .ttc_clk, .rst, .acq_strobe, .chan_trig, .chan_en, .initiate_readout, .send_empty_event,
    .trig_write, .trig_not_full, .acq_write, .acq_not_full
);

// File: tb_trigger_top.sv
// testbench for trigger_top: clock, reset, random stimulus, channel and command manager models, checks
module tb_trigger_top import trigger_pkg::*; ();

    localparam int clk_period   = 100;
    localparam int n_triggers   = 17;   // accepted triggers over all tests
    localparam int worst_cycles = 40;   // delay, dones, readout and gaps per trigger
    localparam int req_timeout  = 40;   // cycles from trigger to request or done

    logic          ttc_clk = 1'b0;
    logic          rst;
    logic          rst_trigger_num, rst_trigger_timestamp;
    logic          ttc_trigger;
    trig_type_t    trig_type;
    chan_mask_t    chan_en;
    delay_t        trig_delay;
    chan_mask_t    chan_dones = '0;      // channel model
    chan_mask_t    chan_trig;
    logic          readout_ready = 1'b1; // command manager always ready
    logic          readout_done = 1'b0;
    logic          initiate_readout, send_empty_event;
    readout_info_t readout_info;
    trig_num_t     trig_num;
    timestamp_t    trig_timestamp;
    logic          error_trig_rate, error_trig_num, error_trig_type;

    // model state
    int          cyc = 0;                 // edge counter
    timestamp_t  ts_ref;                  // cycles since reset or timestamp restart
    trig_num_t   exp_num = '0;            // accepted triggers
    trig_num_t   exp_event = '0;          // logged events
    timestamp_t  last_ts;
    int          errors = 0;
    int          checks = 0;
    int          test_err0;
    int          tests = 0;
    logic [31:0] seed_main = 32'h087b3c0a;
    logic [31:0] seed_chan = 32'h087b3c0a ^ 32'h0000_0101;
    logic [31:0] seed_cmd  = 32'h087b3c0a ^ 32'h0000_0202;
    int          done_wait [n_chan];      // per channel countdown
    int          cmd_wait = 0;

    trigger_top dut0 (.*);

    always #(clk_period / 2) ttc_clk = ~ttc_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ----------------------------------------
    // reference counters
    // ----------------------------------------
    always @(posedge ttc_clk) begin
        cyc <= cyc + 1;
        if (rst || rst_trigger_timestamp) ts_ref <= '0;
        else ts_ref <= ts_ref + timestamp_t'(1);
    end

    // channel model raises each enabled done after 1..8 cycles
    always @(posedge ttc_clk) begin
        if (chan_trig != '0) begin
            chan_dones <= '0;   // held dones drop on the new trigger
            for (int i = 0; i < n_chan; i++) begin
                seed_chan = lcg_next(seed_chan);
                done_wait[i] <= chan_trig[i] ? 1 + int'(seed_chan[23:21]) : 0;
            end
        end else begin
            for (int i = 0; i < n_chan; i++) begin
                if (done_wait[i] != 0) begin
                    done_wait[i] <= done_wait[i] - 1;
                    if (done_wait[i] == 1) chan_dones[i] <= 1'b1;
                end
            end
        end
    end

    // command manager model answers each request after 1..8 cycles
    always @(posedge ttc_clk) begin
        readout_done <= 1'b0;
        if (initiate_readout || send_empty_event) begin
            seed_cmd = lcg_next(seed_cmd);
            cmd_wait <= 1 + int'(seed_cmd[22:20]);
        end else if (cmd_wait != 0) begin
            cmd_wait <= cmd_wait - 1;
            if (cmd_wait == 1) readout_done <= 1'b1;   // one-cycle strobe
        end
    end

    // ----------------------------------------
    // check helpers
    // ----------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_err0 = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        $display("test %-18s %s (%0d errors)", name,
                 (errors == test_err0) ? "ok" : "failed", errors - test_err0);
    endtask

    // one trigger followed up to its readout_done
    task automatic run_trigger(input trig_type_t typ, input chan_mask_t en,
                               input delay_t dly, input bit double_pulse);
        int         acc_cyc;
        int         n;
        int         guard;
        bit         seen_trig;
        bit         seen_req;
        seen_trig = 1'b0;
        seen_req  = 1'b0;
        n         = 0;
        @(posedge ttc_clk);
        ttc_trigger <= 1'b1;
        trig_type   <= typ;
        chan_en     <= en;
        trig_delay  <= dly;
        @(posedge ttc_clk);                // sample edge
        acc_cyc   = cyc;
        exp_num   = exp_num + trig_num_t'(1);
        exp_event = exp_event + trig_num_t'(1);
        last_ts   = ts_ref;                // expected timestamp of this trigger
        ttc_trigger <= double_pulse;       // a second one hits a busy path
        while (!seen_req && n < req_timeout) begin
            @(posedge ttc_clk);
            n = cyc - acc_cyc;
            if (n == 1) begin
                ttc_trigger <= 1'b0;
                check_value("trig_num", 64'(trig_num), 64'(exp_num));
                check_value("trig_timestamp", 64'(trig_timestamp), 64'(last_ts));
            end
            if (double_pulse && n == 2) begin
                check_value("trig_num", 64'(trig_num), 64'(exp_num));  // drop not counted
                check_value("error_trig_rate", 64'(error_trig_rate), 64'(1));
            end
            if (chan_trig != '0) begin
                seen_trig = 1'b1;
                check_value("chan_trig", 64'(chan_trig), 64'(en));
                check_value("chan_trig delay", 64'(n), 64'(dly) + 64'(2));
            end
            if (initiate_readout || send_empty_event) begin
                seen_req = 1'b1;
                check_value("initiate_readout", 64'(initiate_readout), 64'(en != '0));
                check_value("send_empty_event", 64'(send_empty_event), 64'(en == '0));
                check_value("readout_info.trig_num", 64'(readout_info.trig_num), 64'(exp_num));
                check_value("readout_info.event_num", 64'(readout_info.event_num),
                            64'(exp_event));
                check_value("readout_info.trig_type", 64'(readout_info.trig_type), 64'(typ));
                check_value("readout_info.timestamp", 64'(readout_info.timestamp),
                            64'(last_ts));
                check_value("error_trig_num", 64'(error_trig_num), 64'(0));
                check_value("error_trig_type", 64'(error_trig_type), 64'(0));
                last_ts = readout_info.timestamp;
            end
        end
        checks += 2;
        assert (seen_req) else begin
            $display("%0t no readout request within %0d cycles of trigger %0d",
                     $time, req_timeout, exp_num);
            errors++;
        end
        assert (seen_trig == (en != '0)) else begin
            $display("%0t chan_trig %s for trigger %0d", $time,
                     seen_trig ? "fired with no channel enabled" : "never fired", exp_num);
            errors++;
        end
        guard = 0;
        do begin
            @(posedge ttc_clk);
            guard++;
        end while (!readout_done && guard < req_timeout);
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        rst                   = 1'b1;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        ttc_trigger           = 1'b0;
        trig_type             = '0;
        chan_en               = '0;
        trig_delay            = '0;
        repeat (4) @(posedge ttc_clk);
        rst <= 1'b0;
        @(posedge ttc_clk);

        begin_test();   // values right after reset
        check_value("chan_trig", 64'(chan_trig), 64'(0));
        check_value("initiate_readout", 64'(initiate_readout), 64'(0));
        check_value("send_empty_event", 64'(send_empty_event), 64'(0));
        check_value("trig_num", 64'(trig_num), 64'(0));
        check_value("trig_timestamp", 64'(trig_timestamp), 64'(0));
        check_value("error_trig_rate", 64'(error_trig_rate), 64'(0));
        end_test("reset values");

        begin_test();   // random types, delays 0..7, non-zero masks
        for (int k = 0; k < 10; k++) begin
            seed_main = lcg_next(seed_main);
            run_trigger(seed_main[30:28], (seed_main[20:16] == '0) ? 5'b00001 : seed_main[20:16],
                        delay_t'(seed_main[26:24]), 1'b0);
        end
        end_test("numbering delay");

        begin_test();
        for (int k = 0; k < 3; k++) begin
            seed_main = lcg_next(seed_main);
            run_trigger(seed_main[30:28], '0, delay_t'(seed_main[26:24]), 1'b0);
        end
        end_test("empty event");

        begin_test();
        @(posedge ttc_clk);
        rst_trigger_timestamp <= 1'b1;
        @(posedge ttc_clk);
        rst_trigger_timestamp <= 1'b0;
        run_trigger(3'd5, 5'b10101, 32'd3, 1'b0);
        // sampled two edges after the restart edge with one cycle counted
        check_value("timestamp restart", 64'(last_ts), 64'(1));
        end_test("timestamp restart");

        begin_test();
        check_value("error_trig_rate", 64'(error_trig_rate), 64'(0));
        run_trigger(3'd2, 5'b00110, 32'd1, 1'b1);
        run_trigger(3'd7, 5'b11000, 32'd0, 1'b0);
        check_value("error_trig_rate", 64'(error_trig_rate), 64'(1));   // sticky
        end_test("rate error");

        begin_test();
        @(posedge ttc_clk);
        rst_trigger_num <= 1'b1;
        @(posedge ttc_clk);
        rst_trigger_num <= 1'b0;
        exp_num   = '0;
        exp_event = '0;
        run_trigger(3'd1, 5'b01011, 32'd2, 1'b0);
        check_value("trig_num after rst_trigger_num", 64'(trig_num), 64'(1));
        end_test("counter reset");

        check_value("error_trig_num", 64'(error_trig_num), 64'(0));
        check_value("error_trig_type", 64'(error_trig_type), 64'(0));
        check_value("error_trig_rate", 64'(error_trig_rate), 64'(1));
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog at twice the worst case for all triggers
    initial begin
        #(n_triggers * worst_cycles * 2 * clk_period);
        $display("watchdog: run exceeded %0d cycles, stopping",
                 n_triggers * worst_cycles * 2);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: trigger_top.f
trigger_pkg.sv
ttc_trigger_receiver.sv
channel_acq_controller.sv
record_fifo.sv
trigger_processor.sv
trigger_top.sv
trigger_top_asserts.sv
tb_trigger_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the trigger path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_trigger_top -f trigger_top.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation ok"
else
    echo "simulation failed"
    exit 1
fi
